// ==== hdl/c64_pkg.sv ====
//======================================================================
// Shared types and constants for the loader and tape path
//======================================================================
`default_nettype none

package c64_pkg;

	// Basic data types
	typedef logic [24:0] addr_t;
	typedef logic [7:0] byte_t;
	typedef logic signed [15:0] sample_t;
	typedef logic signed [17:0] sid_sample_t;

	// Tape image region in main memory
	localparam addr_t TAP_BASE = 25'h0200000;
	// Extra bytes the tape end address carries past the last download byte
	localparam addr_t TAP_TAIL = 25'd2;

	// Download index codes from the host
	localparam byte_t IDX_PRG = 8'd4;
	localparam byte_t IDX_TAP = 8'd6;

	// Zero-page scan limit
	localparam addr_t ZP_END = 25'h0000100;

	// BASIC text start pointer and its reset value
	localparam addr_t ZP_TXT_LO = 25'h000002B;
	localparam addr_t ZP_TXT_HI = 25'h000002C;
	localparam byte_t TXT_START_LO = 8'h01;
	localparam byte_t TXT_START_HI = 8'h08;

	// SAVE start pointer, cleared
	localparam addr_t ZP_SAVE_LO = 25'h00000AC;
	localparam addr_t ZP_SAVE_HI = 25'h00000AD;

	// VAR, ARY, STR and LOAD end pointers all take the end address
	localparam addr_t ZP_VAR_LO = 25'h000002D;
	localparam addr_t ZP_VAR_HI = 25'h000002E;
	localparam addr_t ZP_ARY_LO = 25'h000002F;
	localparam addr_t ZP_ARY_HI = 25'h0000030;
	localparam addr_t ZP_STR_LO = 25'h0000031;
	localparam addr_t ZP_STR_HI = 25'h0000032;
	localparam addr_t ZP_LEND_LO = 25'h00000AE;
	localparam addr_t ZP_LEND_HI = 25'h00000AF;

endpackage

`default_nettype wire

// ==== hdl/dl_decoder.sv ====
//======================================================================
// Download decoder for PRG and TAP files
// Issues memory writes and sets up the BASIC pointers after a PRG load
//======================================================================
`default_nettype none

module dl_decoder (
	input  wire                 clk_sys,
	input  wire                 reset_n,
	input  wire                 dl_active_i,
	input  wire c64_pkg::byte_t dl_index_i,
	input  wire c64_pkg::addr_t dl_addr_i,
	input  wire                 dl_wr_i,
	input  wire c64_pkg::byte_t dl_data_i,
	input  wire                 wr_ack_i,
	output logic                dl_wait_o,
	output logic                wr_req_o,
	output c64_pkg::addr_t      wr_addr_o,
	output c64_pkg::byte_t      wr_data_o,
	output logic                tap_dl_o,
	output c64_pkg::addr_t      tap_last_o
);

	logic is_prg;
	logic is_tap;
	logic prg_wr;
	logic hdr_lo;
	logic hdr_hi;
	logic prg_data;
	logic tap_data;
	logic data_wr;
	logic prg_dl;
	logic active_d;
	logic zp_busy;
	logic zp_start;
	logic zp_step;
	logic zp_issue;
	logic zp_hit;
	c64_pkg::byte_t zp_val;
	c64_pkg::addr_t zp_addr;
	logic [15:0] load_addr;
	logic [15:0] end_addr;

	assign is_prg = (dl_index_i == c64_pkg::IDX_PRG);
	assign is_tap = (dl_index_i == c64_pkg::IDX_TAP);
	assign tap_dl_o = dl_active_i & is_tap;

	// First two PRG bytes are the load address
	assign prg_wr = dl_wr_i & dl_active_i & is_prg;
	assign hdr_lo = prg_wr & (dl_addr_i == 25'd0);
	assign hdr_hi = prg_wr & (dl_addr_i == 25'd1);
	assign prg_data = prg_wr & (dl_addr_i > 25'd1);
	assign tap_data = dl_wr_i & tap_dl_o;
	assign data_wr = prg_data | tap_data;

	// Pointer setup runs once the PRG stream has ended
	assign zp_start = active_d & ~dl_active_i & prg_dl;
	assign zp_step = zp_busy & ~wr_req_o & (zp_addr != c64_pkg::ZP_END);
	assign zp_issue = zp_step & zp_hit;

	//======================================================================
	// Zero-page pointer table
	//======================================================================
	always_comb begin
		zp_hit = 1'b1;
		zp_val = 8'h00;
		case (zp_addr)
			c64_pkg::ZP_TXT_LO: zp_val = c64_pkg::TXT_START_LO;
			c64_pkg::ZP_TXT_HI: zp_val = c64_pkg::TXT_START_HI;
			c64_pkg::ZP_SAVE_LO, c64_pkg::ZP_SAVE_HI: zp_val = 8'h00;
			c64_pkg::ZP_VAR_LO, c64_pkg::ZP_ARY_LO,
			c64_pkg::ZP_STR_LO, c64_pkg::ZP_LEND_LO: zp_val = end_addr[7:0];
			c64_pkg::ZP_VAR_HI, c64_pkg::ZP_ARY_HI,
			c64_pkg::ZP_STR_HI, c64_pkg::ZP_LEND_HI: zp_val = end_addr[15:8];
			default: zp_hit = 1'b0;
		endcase
	end

	//======================================================================
	// Request and wait handshake
	//======================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			active_d <= 1'b0;
			prg_dl <= 1'b0;
			zp_busy <= 1'b0;
			wr_req_o <= 1'b0;
			dl_wait_o <= 1'b0;
		end else begin
			active_d <= dl_active_i;
			if (dl_active_i) begin
				prg_dl <= is_prg;
			end
			if (wr_ack_i) begin
				wr_req_o <= 1'b0;
				dl_wait_o <= 1'b0;
			end
			if (data_wr | zp_issue) begin
				wr_req_o <= 1'b1;
			end
			// Only payload bytes make the host wait
			if (data_wr) begin
				dl_wait_o <= 1'b1;
			end
			if (zp_start) begin
				zp_busy <= 1'b1;
			end else if (zp_busy & ~wr_req_o & (zp_addr == c64_pkg::ZP_END)) begin
				zp_busy <= 1'b0;
			end
		end
	end

	// Addresses and data
	always_ff @(posedge clk_sys) begin
		if (hdr_lo) begin
			load_addr[7:0] <= dl_data_i;
			end_addr[7:0] <= dl_data_i;
		end
		if (hdr_hi) begin
			load_addr[15:8] <= dl_data_i;
			end_addr[15:8] <= dl_data_i;
		end
		if (prg_data) begin
			wr_addr_o <= {9'd0, load_addr};
			wr_data_o <= dl_data_i;
			load_addr <= load_addr + 16'd1;
			end_addr <= end_addr + 16'd1;
		end
		if (tap_data) begin
			wr_addr_o <= c64_pkg::TAP_BASE + dl_addr_i;
			wr_data_o <= dl_data_i;
			tap_last_o <= dl_addr_i + c64_pkg::TAP_TAIL;
		end
		if (zp_start) begin
			zp_addr <= '0;
		end else if (zp_step) begin
			zp_addr <= zp_addr + 25'd1;
		end
		if (zp_issue) begin
			wr_addr_o <= zp_addr;
			wr_data_o <= zp_val;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/mem_slot_sched.sv ====
//======================================================================
// Memory slot scheduler
// One access per free CPU slot, writes ahead of tape reads
//======================================================================
`default_nettype none

module mem_slot_sched (
	input  wire                 clk_sys,
	input  wire                 reset_n,
	input  wire                 io_cycle_i,
	input  wire                 wr_req_i,
	input  wire c64_pkg::addr_t wr_addr_i,
	input  wire c64_pkg::byte_t wr_data_i,
	input  wire                 rd_req_i,
	input  wire c64_pkg::addr_t rd_offs_i,
	input  wire c64_pkg::byte_t mem_rdata_i,
	output logic                mem_ce_o,
	output logic                mem_we_o,
	output c64_pkg::addr_t      mem_addr_o,
	output c64_pkg::byte_t      mem_data_o,
	output logic                wr_ack_o,
	output logic                rd_ack_o,
	output c64_pkg::byte_t      rd_data_o
);

	logic io_d;
	logic slot_open;
	logic slot_close;

	// Falling edge opens the slot, second high cycle closes it
	assign slot_open = io_d & ~io_cycle_i;
	assign slot_close = io_d & io_cycle_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_d <= 1'b0;
			mem_ce_o <= 1'b0;
			mem_we_o <= 1'b0;
			wr_ack_o <= 1'b0;
			rd_ack_o <= 1'b0;
		end else begin
			io_d <= io_cycle_i;
			wr_ack_o <= 1'b0;
			rd_ack_o <= 1'b0;
			if (slot_open & (wr_req_i | rd_req_i)) begin
				mem_ce_o <= 1'b1;
				mem_we_o <= wr_req_i;
			end
			if (slot_close & mem_ce_o) begin
				mem_ce_o <= 1'b0;
				mem_we_o <= 1'b0;
				wr_ack_o <= mem_we_o;
				rd_ack_o <= ~mem_we_o;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (slot_open) begin
			if (wr_req_i) begin
				mem_addr_o <= wr_addr_i;
				mem_data_o <= wr_data_i;
			end else begin
				mem_addr_o <= c64_pkg::TAP_BASE + rd_offs_i;
			end
		end
		if (slot_close & mem_ce_o & ~mem_we_o) begin
			rd_data_o <= mem_rdata_i;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tape_fetch.sv ====
//======================================================================
// Tape fetch control
// Play offset, loaded length, play state and read credits
//======================================================================
`default_nettype none

module tape_fetch #(
	parameter int TAPE_CREDITS = 4
) (
	input  wire                 clk_sys,
	input  wire                 reset_n,
	input  wire                 tap_dl_i,
	input  wire c64_pkg::addr_t tap_last_i,
	input  wire                 tape_btn_i,
	input  wire                 tape_unload_i,
	input  wire                 rd_ack_i,
	input  wire                 credit_ret_i,
	output logic                rd_req_o,
	output c64_pkg::addr_t      rd_offs_o,
	output logic                play_on_o
);

	localparam int CW = $clog2(TAPE_CREDITS + 1);

	logic restart;
	logic tap_dl_d;
	logic btn_d;
	c64_pkg::addr_t last_addr;
	logic [CW-1:0] credit_cnt;

	assign restart = tap_dl_i | tape_unload_i;
	// One read per free buffer entry
	assign rd_req_o = ~restart & (credit_cnt != '0) & (rd_offs_o < last_addr);

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			tap_dl_d <= 1'b0;
			btn_d <= 1'b0;
			play_on_o <= 1'b0;
			rd_offs_o <= '0;
			last_addr <= '0;
			credit_cnt <= CW'(TAPE_CREDITS);
		end else begin
			tap_dl_d <= tap_dl_i;
			btn_d <= tape_btn_i;
			if (restart) begin
				rd_offs_o <= '0;
				last_addr <= tap_dl_i ? tap_last_i : '0;
				play_on_o <= 1'b0;
			end else begin
				if (rd_ack_i) begin
					rd_offs_o <= rd_offs_o + 25'd1;
				end
				// Download just ended, pick up the final length and start
				if (tap_dl_d) begin
					last_addr <= tap_last_i;
					play_on_o <= 1'b1;
				end else if (tape_btn_i & ~btn_d) begin
					play_on_o <= ~play_on_o;
				end
			end
			case ({rd_ack_i, credit_ret_i})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tape_pulse.sv ====
//======================================================================
// Cassette pulse generator
// Buffers tape bytes and times each level of the cassette line
//======================================================================
`default_nettype none

module tape_pulse #(
	parameter int CLK_PER_US = 32,
	parameter int TAPE_CREDITS = 4
) (
	input  wire                 clk_sys,
	input  wire                 reset_n,
	input  wire                 push_i,
	input  wire c64_pkg::byte_t push_data_i,
	input  wire                 play_on_i,
	input  wire                 cass_motor_i,
	output logic                credit_ret_o,
	output logic                cass_data_o
);

	localparam int PW = (TAPE_CREDITS > 1) ? $clog2(TAPE_CREDITS) : 1;
	localparam int CW = $clog2(TAPE_CREDITS + 1);
	localparam int SW = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;

	c64_pkg::byte_t fifo_mem [TAPE_CREDITS];
	c64_pkg::byte_t head;
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] fill;
	logic [SW-1:0] pre_cnt;
	logic [11:0] us_cnt;
	logic active;
	logic run;
	logic tick;
	logic expire;
	logic pop;

	function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
		if (p == PW'(TAPE_CREDITS - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign head = fifo_mem[rd_ptr];
	assign run = play_on_i & ~cass_motor_i;
	assign tick = active & run & (pre_cnt == SW'(CLK_PER_US - 1));
	assign expire = tick & (us_cnt == 12'd1);
	// Next byte loads in the same cycle the level expires
	assign pop = run & (fill != '0) & (~active | expire);

	always_ff @(posedge clk_sys) begin
		if (push_i) begin
			fifo_mem[wr_ptr] <= push_data_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			active <= 1'b0;
			pre_cnt <= '0;
			us_cnt <= '0;
			credit_ret_o <= 1'b0;
			cass_data_o <= 1'b0;
		end else begin
			credit_ret_o <= pop;
			if (push_i) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({push_i, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
			if (expire) begin
				cass_data_o <= ~cass_data_o;
			end
			if (pop) begin
				// Byte b gives b*8 us, zero stands for 256
				active <= 1'b1;
				pre_cnt <= '0;
				us_cnt <= {head == 8'd0, head, 3'b000};
			end else begin
				if (expire) begin
					active <= 1'b0;
				end
				if (tick) begin
					pre_cnt <= '0;
					us_cnt <= us_cnt - 12'd1;
				end else if (active & run) begin
					pre_cnt <= pre_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/audio_mix.sv ====
//======================================================================
// Audio mixer with 16-bit saturation per channel
//======================================================================
`default_nettype none

module audio_mix (
	input  wire                       clk_sys,
	input  wire                       reset_n,
	input  wire c64_pkg::sid_sample_t sid_l_i,
	input  wire c64_pkg::sid_sample_t sid_r_i,
	input  wire c64_pkg::sample_t     opl_i,
	input  wire                       cass_i,
	input  wire                       play_on_i,
	input  wire                       cass_motor_i,
	input  wire                       tape_snd_en_i,
	output c64_pkg::sample_t          audio_l_o,
	output c64_pkg::sample_t          audio_r_o
);

	logic tape_snd;
	logic signed [16:0] sum_l;
	logic signed [16:0] sum_r;

	function automatic c64_pkg::sample_t clamp16(input logic signed [16:0] v);
		if (v > 17'sd32767) begin
			return 16'sh7fff;
		end
		if (v < -17'sd32768) begin
			return 16'sh8000;
		end
		return v[15:0];
	endfunction

	// Tape is heard only while it actually runs
	assign tape_snd = cass_i & tape_snd_en_i & play_on_i & ~cass_motor_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			sum_l <= '0;
			sum_r <= '0;
			audio_l_o <= '0;
			audio_r_o <= '0;
		end else begin
			sum_l <= {opl_i[15], opl_i} + {sid_l_i[17], sid_l_i[17:2]} + {6'd0, tape_snd, 10'd0};
			sum_r <= {opl_i[15], opl_i} + {sid_r_i[17], sid_r_i[17:2]} + {6'd0, tape_snd, 10'd0};
			audio_l_o <= clamp16(sum_l);
			audio_r_o <= clamp16(sum_r);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/c64_loader_top.sv ====
//======================================================================
// Loader and tape top level
// Download decoding, memory slot use, tape playback and audio mix
//======================================================================
`default_nettype none

module c64_loader_top #(
	parameter int CLK_PER_US = 32,
	parameter int TAPE_CREDITS = 4
) (
	input  wire                       clk_sys,
	input  wire                       reset_n,
	input  wire                       dl_active_i,
	input  wire c64_pkg::byte_t       dl_index_i,
	input  wire c64_pkg::addr_t       dl_addr_i,
	input  wire                       dl_wr_i,
	input  wire c64_pkg::byte_t       dl_data_i,
	input  wire                       io_cycle_i,
	input  wire c64_pkg::byte_t       mem_rdata_i,
	input  wire                       tape_btn_i,
	input  wire                       tape_unload_i,
	input  wire                       cass_motor_i,
	input  wire                       tape_snd_en_i,
	input  wire c64_pkg::sid_sample_t sid_l_i,
	input  wire c64_pkg::sid_sample_t sid_r_i,
	input  wire c64_pkg::sample_t     opl_i,
	output logic                      dl_wait_o,
	output logic                      mem_ce_o,
	output logic                      mem_we_o,
	output c64_pkg::addr_t            mem_addr_o,
	output c64_pkg::byte_t            mem_data_o,
	output logic                      cass_data_o,
	output c64_pkg::sample_t          audio_l_o,
	output c64_pkg::sample_t          audio_r_o
);

	// Write path
	logic wr_req;
	c64_pkg::addr_t wr_addr;
	c64_pkg::byte_t wr_data;
	logic wr_ack;

	// Tape read path
	logic rd_req;
	c64_pkg::addr_t rd_offs;
	logic rd_ack;
	c64_pkg::byte_t rd_data;
	logic tap_dl;
	c64_pkg::addr_t tap_last;
	logic play_on;
	logic credit_ret;

	dl_decoder dec0 (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_addr_i   (dl_addr_i),
		.dl_wr_i     (dl_wr_i),
		.dl_data_i   (dl_data_i),
		.wr_ack_i    (wr_ack),
		.dl_wait_o   (dl_wait_o),
		.wr_req_o    (wr_req),
		.wr_addr_o   (wr_addr),
		.wr_data_o   (wr_data),
		.tap_dl_o    (tap_dl),
		.tap_last_o  (tap_last)
	);

	mem_slot_sched sched0 (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.io_cycle_i  (io_cycle_i),
		.wr_req_i    (wr_req),
		.wr_addr_i   (wr_addr),
		.wr_data_i   (wr_data),
		.rd_req_i    (rd_req),
		.rd_offs_i   (rd_offs),
		.mem_rdata_i (mem_rdata_i),
		.mem_ce_o    (mem_ce_o),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o),
		.wr_ack_o    (wr_ack),
		.rd_ack_o    (rd_ack),
		.rd_data_o   (rd_data)
	);

	tape_fetch #(
		.TAPE_CREDITS (TAPE_CREDITS)
	) fetch0 (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.tap_dl_i      (tap_dl),
		.tap_last_i    (tap_last),
		.tape_btn_i    (tape_btn_i),
		.tape_unload_i (tape_unload_i),
		.rd_ack_i      (rd_ack),
		.credit_ret_i  (credit_ret),
		.rd_req_o      (rd_req),
		.rd_offs_o     (rd_offs),
		.play_on_o     (play_on)
	);

	// Each read ack pushes its byte into the pulse buffer
	tape_pulse #(
		.CLK_PER_US   (CLK_PER_US),
		.TAPE_CREDITS (TAPE_CREDITS)
	) pulse0 (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.push_i       (rd_ack),
		.push_data_i  (rd_data),
		.play_on_i    (play_on),
		.cass_motor_i (cass_motor_i),
		.credit_ret_o (credit_ret),
		.cass_data_o  (cass_data_o)
	);

	audio_mix mix0 (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.sid_l_i       (sid_l_i),
		.sid_r_i       (sid_r_i),
		.opl_i         (opl_i),
		.cass_i        (cass_data_o),
		.play_on_i     (play_on),
		.cass_motor_i  (cass_motor_i),
		.tape_snd_en_i (tape_snd_en_i),
		.audio_l_o     (audio_l_o),
		.audio_r_o     (audio_r_o)
	);

endmodule

`default_nettype wire

// ==== bench/tb_monitor.sv ====
//======================================================================
// Checker for the loader top level
// Shadow memory, cassette toggle times and audio comparison
//======================================================================
`default_nettype none

module tb_monitor (
	input  wire                   clk_sys,
	input  wire                   reset_n,
	input  wire                   mem_ce_i,
	input  wire                   mem_we_i,
	input  wire c64_pkg::addr_t   mem_addr_i,
	input  wire c64_pkg::byte_t   mem_data_i,
	input  wire                   cass_i,
	input  wire c64_pkg::sample_t audio_l_i,
	input  wire c64_pkg::sample_t audio_r_i,
	input  wire                   exp_valid_i,
	input  wire c64_pkg::sample_t exp_l_i,
	input  wire c64_pkg::sample_t exp_r_i,
	output int                    toggle_cnt_o,
	output int                    zp_wr_cnt_o,
	output int                    err_cnt_o
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0] shadow [int];
	int toggles [$];
	int cycle = 0;
	int errs = 0;
	int zp_cnt = 0;
	logic ce_d = 1'b0;
	logic cass_d = 1'b0;
	logic v1 = 1'b0;
	logic v2 = 1'b0;
	c64_pkg::sample_t l1, l2, r1, r2;

	assign toggle_cnt_o = toggles.size();
	assign zp_wr_cnt_o = zp_cnt;
	assign err_cnt_o = errs;

	always @(posedge clk_sys) begin
		cycle++;
	end

	// Everything is sampled mid-cycle where outputs are settled
	always @(negedge clk_sys) begin
		if (mem_ce_i && mem_we_i && !ce_d) begin
			shadow[int'(mem_addr_i)] = mem_data_i;
			if (mem_addr_i < c64_pkg::ZP_END) begin
				zp_cnt++;
			end
		end
		ce_d = mem_ce_i;
		if (reset_n && cass_i != cass_d) begin
			toggles.push_back(cycle);
		end
		cass_d = cass_i;
		// Output two clocks after the entry went in
		if (v2 && (audio_l_i !== l2 || audio_r_i !== r2)) begin
			$display("ERR %0t: audio got %0d/%0d, expected %0d/%0d",
				$time, audio_l_i, audio_r_i, l2, r2);
			errs++;
		end
		v2 = v1;
		l2 = l1;
		r2 = r1;
		v1 = exp_valid_i;
		l1 = exp_l_i;
		r1 = exp_r_i;
	end

	task automatic check_byte(input c64_pkg::addr_t a, input c64_pkg::byte_t exp);
		if (!shadow.exists(int'(a))) begin
			$display("ERR %0t: address %h was never written", $time, a);
			errs++;
		end else if (shadow[int'(a)] !== exp) begin
			$display("ERR %0t: address %h holds %h, expected %h", $time, a, shadow[int'(a)], exp);
			errs++;
		end
	endtask

	task automatic check_zp_count(input int exp);
		if (zp_cnt != exp) begin
			$display("ERR %0t: %0d zero-page writes, expected %0d", $time, zp_cnt, exp);
			errs++;
		end
	endtask

	task automatic check_gap(input int k, input int exp);
		if (toggles.size() <= k) begin
			$display("ERR %0t: toggle %0d never seen", $time, k);
			errs++;
		end else if (toggles[k] - toggles[k-1] != exp) begin
			$display("ERR %0t: toggle gap %0d is %0d clocks, expected %0d",
				$time, k, toggles[k] - toggles[k-1], exp);
			errs++;
		end
	endtask

	task automatic check_no_toggle(input int held);
		if (toggles.size() != held) begin
			$display("ERR %0t: cassette line toggled while paused", $time);
			errs++;
		end
	endtask

endmodule

`default_nettype wire

// ==== bench/tb_loader_chk.sv ====
//======================================================================
// Assertions on the slot scheduler and the tape credit counter
//======================================================================
`default_nettype none

module tb_loader_chk #(
	parameter int LIMIT = 4
) (
	input wire       clk_sys,
	input wire       reset_n,
	input wire       slot_ce,
	input wire       io_cycle,
	input wire [7:0] credit_cnt
);
	timeunit 1ns;
	timeprecision 100ps;

	// A slot only opens in the low phase
	assert property (@(posedge clk_sys) disable iff (!reset_n) $rose(slot_ce) |-> !io_cycle)
		else $error("mem_ce_o rose during a high io_cycle_i phase");

	assert property (@(posedge clk_sys) disable iff (!reset_n) credit_cnt <= 8'(LIMIT))
		else $error("tape credit count above the buffer depth");

endmodule

bind mem_slot_sched tb_loader_chk #(.LIMIT(4)) slot_chk0 (
	.clk_sys (clk_sys), .reset_n (reset_n), .slot_ce (mem_ce_o),
	.io_cycle (io_cycle_i), .credit_cnt (8'd0)
);

bind tape_fetch tb_loader_chk #(.LIMIT(TAPE_CREDITS)) credit_chk0 (
	.clk_sys (clk_sys), .reset_n (reset_n), .slot_ce (1'b0),
	.io_cycle (1'b0), .credit_cnt (8'(credit_cnt))
);

`default_nettype wire

// ==== bench/tb_c64_loader.sv ====
//======================================================================
// Testbench for the loader and tape top level
// PRG and TAP downloads, tape pulse timing and audio saturation
//======================================================================
`default_nettype none

module tb_c64_loader;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PER_US = 2;
	localparam int TAPE_CREDITS = 4;
	localparam int PRG_LEN = 40;
	localparam int TAP_LEN = 8;
	localparam int AUD_LEN = 6;
	// Text start, SAVE start and four end pointers, two bytes each
	localparam int ZP_WRITES = 12;

	logic clk_sys = 1'b0;
	logic reset_n;
	logic dl_active, dl_wr, io_cycle, tape_btn, tape_unload, cass_motor, tape_snd_en;
	c64_pkg::byte_t dl_index, dl_data, mem_rdata, mem_data;
	c64_pkg::addr_t dl_addr, mem_addr;
	c64_pkg::sid_sample_t sid_l, sid_r;
	c64_pkg::sample_t opl, audio_l, audio_r, exp_l, exp_r;
	logic dl_wait, mem_ce, mem_we, cass_data, exp_valid;
	int toggle_cnt, zp_wr_cnt, mon_errs;
	int tb_errs = 0;
	logic [31:0] lfsr_state = 32'he77d_f75e;
	c64_pkg::byte_t prg_bytes [PRG_LEN];
	logic [7:0] mem_model [int];

	// Tape bytes, the first one only leads in
	c64_pkg::byte_t tap_tab [TAP_LEN] = '{8'd3, 8'd1, 8'd5, 8'd0, 8'd2, 8'd4, 8'd1, 8'd6};

	// Audio stimulus and clamped expected sums
	int aud_sid_l [AUD_LEN] = '{4000, 131071, -131072, -5, 40000, -100000};
	int aud_sid_r [AUD_LEN] = '{-4000, 0, 4, 7, -40000, 100000};
	int aud_opl [AUD_LEN] = '{100, 32767, -32768, 0, 30000, -10000};
	int aud_exp_l [AUD_LEN] = '{1100, 32767, -32768, -2, 32767, -32768};
	int aud_exp_r [AUD_LEN] = '{-900, 32767, -32767, 1, 20000, 15000};

	always #20 clk_sys = ~clk_sys;

	c64_loader_top #(
		.CLK_PER_US   (CLK_PER_US),
		.TAPE_CREDITS (TAPE_CREDITS)
	) dut0 (
		.clk_sys (clk_sys), .reset_n (reset_n),
		.dl_active_i (dl_active), .dl_index_i (dl_index), .dl_addr_i (dl_addr),
		.dl_wr_i (dl_wr), .dl_data_i (dl_data), .io_cycle_i (io_cycle),
		.mem_rdata_i (mem_rdata), .tape_btn_i (tape_btn), .tape_unload_i (tape_unload),
		.cass_motor_i (cass_motor), .tape_snd_en_i (tape_snd_en),
		.sid_l_i (sid_l), .sid_r_i (sid_r), .opl_i (opl),
		.dl_wait_o (dl_wait), .mem_ce_o (mem_ce), .mem_we_o (mem_we),
		.mem_addr_o (mem_addr), .mem_data_o (mem_data), .cass_data_o (cass_data),
		.audio_l_o (audio_l), .audio_r_o (audio_r)
	);

	tb_monitor mon0 (
		.clk_sys (clk_sys), .reset_n (reset_n),
		.mem_ce_i (mem_ce), .mem_we_i (mem_we), .mem_addr_i (mem_addr),
		.mem_data_i (mem_data), .cass_i (cass_data),
		.audio_l_i (audio_l), .audio_r_i (audio_r),
		.exp_valid_i (exp_valid), .exp_l_i (exp_l), .exp_r_i (exp_r),
		.toggle_cnt_o (toggle_cnt), .zp_wr_cnt_o (zp_wr_cnt), .err_cnt_o (mon_errs)
	);

	// Unwritten bytes follow a pattern over the whole address
	function automatic c64_pkg::byte_t fill_byte(input c64_pkg::addr_t a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]};
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int tape_clocks(input c64_pkg::byte_t b);
		return ((b == 8'd0) ? 256 : int'(b)) * 8 * CLK_PER_US;
	endfunction

	//======================================================================
	// Memory model
	//======================================================================
	always @(negedge clk_sys) begin
		if (mem_ce && mem_we) begin
			mem_model[int'(mem_addr)] = mem_data;
		end
	end

	always @* begin
		if (mem_model.exists(int'(mem_addr))) begin
			mem_rdata = mem_model[int'(mem_addr)];
		end else begin
			mem_rdata = fill_byte(mem_addr);
		end
	end

	task automatic step();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic next_rand_byte(output c64_pkg::byte_t b);
		b = 8'd0;
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
	endtask

	// One strobe, then hold off while the DUT asks the host to wait
	task automatic send_byte(input c64_pkg::addr_t a, input c64_pkg::byte_t d);
		int n;
		dl_addr = a;
		dl_data = d;
		dl_wr = 1'b1;
		step();
		dl_wr = 1'b0;
		step();
		n = 0;
		while (dl_wait && n < 200) begin
			step();
			n++;
		end
		if (dl_wait) begin
			$display("Timeout: dl_wait_o stayed high after a download byte");
			tb_errs++;
		end
	endtask

	task automatic run_audio();
		for (int i = 0; i < AUD_LEN; i++) begin
			sid_l = 18'(aud_sid_l[i]);
			sid_r = 18'(aud_sid_r[i]);
			opl = 16'(aud_opl[i]);
			exp_l = 16'(aud_exp_l[i]);
			exp_r = 16'(aud_exp_r[i]);
			exp_valid = 1'b1;
			step();
		end
		exp_valid = 1'b0;
		repeat (4) step();
	endtask

	task automatic run_prg();
		int n;
		dl_index = c64_pkg::IDX_PRG;
		dl_active = 1'b1;
		step();
		send_byte(25'd0, 8'h01);
		send_byte(25'd1, 8'h08);
		for (int i = 0; i < PRG_LEN; i++) begin
			next_rand_byte(prg_bytes[i]);
			send_byte(25'(i + 2), prg_bytes[i]);
		end
		dl_active = 1'b0;
		n = 0;
		while (zp_wr_cnt < ZP_WRITES && n < 3000) begin
			step();
			n++;
		end
		if (zp_wr_cnt < ZP_WRITES) begin
			$display("Timeout: zero-page pointer writes did not finish");
			tb_errs++;
		end
		// Let the scan run out to the end of zero page
		repeat (400) step();
		for (int i = 0; i < PRG_LEN; i++) begin
			mon0.check_byte(25'h801 + 25'(i), prg_bytes[i]);
		end
		mon0.check_byte(c64_pkg::ZP_TXT_LO, 8'h01);
		mon0.check_byte(c64_pkg::ZP_TXT_HI, 8'h08);
		mon0.check_byte(c64_pkg::ZP_SAVE_LO, 8'h00);
		mon0.check_byte(c64_pkg::ZP_SAVE_HI, 8'h00);
		mon0.check_byte(25'h2D, 8'h29);
		mon0.check_byte(25'h2F, 8'h29);
		mon0.check_byte(25'h31, 8'h29);
		mon0.check_byte(25'hAE, 8'h29);
		mon0.check_byte(25'h2E, 8'h08);
		mon0.check_byte(25'h30, 8'h08);
		mon0.check_byte(25'h32, 8'h08);
		mon0.check_byte(25'hAF, 8'h08);
		mon0.check_zp_count(ZP_WRITES);
	endtask

	task automatic run_tape();
		int n;
		int limit;
		int held;
		dl_index = c64_pkg::IDX_TAP;
		dl_active = 1'b1;
		step();
		for (int i = 0; i < TAP_LEN; i++) begin
			send_byte(25'(i), tap_tab[i]);
		end
		dl_active = 1'b0;
		step();
		for (int i = 0; i < TAP_LEN; i++) begin
			mon0.check_byte(c64_pkg::TAP_BASE + 25'(i), tap_tab[i]);
		end
		limit = 500;
		for (int i = 0; i < TAP_LEN; i++) begin
			limit += tape_clocks(tap_tab[i]);
		end
		n = 0;
		while (toggle_cnt < TAP_LEN && n < limit) begin
			step();
			n++;
		end
		if (toggle_cnt < TAP_LEN) begin
			$display("Timeout: cassette output stopped toggling early");
			tb_errs++;
		end
		// Pause playback, then the line must stay still
		tape_btn = 1'b1;
		step();
		step();
		tape_btn = 1'b0;
		held = toggle_cnt;
		for (int k = 1; k < TAP_LEN; k++) begin
			mon0.check_gap(k, tape_clocks(tap_tab[k]));
		end
		repeat (1000) step();
		mon0.check_no_toggle(held);
	endtask

	initial begin
		reset_n = 1'b0;
		dl_active = 1'b0;
		dl_index = 8'd0;
		dl_addr = '0;
		dl_wr = 1'b0;
		dl_data = 8'd0;
		io_cycle = 1'b0;
		tape_btn = 1'b0;
		tape_unload = 1'b0;
		cass_motor = 1'b0;
		tape_snd_en = 1'b0;
		sid_l = '0;
		sid_r = '0;
		opl = '0;
		exp_valid = 1'b0;
		exp_l = '0;
		exp_r = '0;
		repeat (10) @(posedge clk_sys);
		#2;
		reset_n = 1'b1;
		step();
		run_audio();
		run_prg();
		run_tape();
		$display("Error counts: monitor %0d, testbench %0d", mon_errs, tb_errs);
		if (mon_errs + tb_errs == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Free memory slots every 4 clocks
	initial begin
		forever begin
			repeat (4) @(posedge clk_sys);
			#2;
			io_cycle = ~io_cycle;
		end
	end

	initial begin
		int cycles;
		cycles = 10 + AUD_LEN + 10 + (PRG_LEN + 2) * 24 + 3000 + TAP_LEN * 24 + 2000;
		for (int i = 0; i < TAP_LEN; i++) begin
			cycles += tape_clocks(tap_tab[i]);
		end
		#(cycles * 2 * 40);
		$display("Watchdog: the run took longer than its time limit");
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/c64_pkg.sv
hdl/dl_decoder.sv
hdl/mem_slot_sched.sv
hdl/tape_fetch.sv
hdl/tape_pulse.sv
hdl/audio_mix.sv
hdl/c64_loader_top.sv
bench/tb_monitor.sv
bench/tb_loader_chk.sv
bench/tb_c64_loader.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the loader testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_c64_loader -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
